// File: Bender.yml
package:
  name: video_out

sources:
  - hw/video_pkg.sv
  - hw/video_timing_if.sv
  - hw/vga_sync_pulses.sv
  - hw/sync_to_blanking.sv
  - hw/frame_measure.sv
  - hw/line_buffer_ram.sv
  - hw/upscaler.sv
  - hw/video_out_top.sv
  - target: simulation
    files:
      - sim/video_out_tb.sv

// File: all.f
hw/video_pkg.sv
hw/video_timing_if.sv
hw/vga_sync_pulses.sv
hw/sync_to_blanking.sv
hw/frame_measure.sv
hw/line_buffer_ram.sv
hw/upscaler.sv
hw/video_out_top.sv
sim/video_out_tb.sv

// File: hw/frame_measure.sv
`timescale 1ns/100ps

module frame_measure (
	input  logic i_clk,
	input  logic i_rst_n,
	video_timing_if.snk i_timing,
	output logic o_locked,
	output video_pkg::dim_t o_width,
	output video_pkg::dim_t o_height
);

	import video_pkg::*;

	logic [1:0] rst_sync;
	logic rst_n;
	logic active;
	logic active_q;
	logic vs_q;
	logic line_end;
	logic frame_end;
	dim_t pix_cnt;
	dim_t line_width;
	dim_t line_cnt;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rst_sync <= 2'b00;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
		end
	end

	assign rst_n = rst_sync[1];

	assign active = !i_timing.hblank && !i_timing.vblank;
	assign line_end = active_q && !active;
	// Frame boundary is the vsync falling edge
	assign frame_end = vs_q && !i_timing.vsync_n;

	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			vs_q <= 1'b1;
			pix_cnt <= '0;
			line_width <= '0;
			line_cnt <= '0;
			o_locked <= 1'b0;
			o_width <= '0;
			o_height <= '0;
		end else begin
			active_q <= active;
			vs_q <= i_timing.vsync_n;

			if (active) begin
				pix_cnt <= pix_cnt + 1'b1;
			end else begin
				pix_cnt <= '0;
			end

			// pix_cnt still holds the finished line here
			if (line_end) begin
				line_width <= pix_cnt;
				line_cnt <= line_cnt + 1'b1;
			end

			if (frame_end) begin
				o_width <= line_width;
				o_height <= line_cnt;
				// Lock only on two matching nonzero frames in a row
				o_locked <= line_width != '0 && line_cnt != '0 &&
					line_width == o_width && line_cnt == o_height;
				line_width <= '0;
				line_cnt <= '0;
			end
		end
	end

endmodule

// File: hw/line_buffer_ram.sv
`timescale 1ns/100ps

module line_buffer_ram #(
	parameter int DATA_WIDTH = 12,
	parameter int DEPTH = 1024
) (
	input  logic i_clk_wr,
	input  logic i_we,
	input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
	input  logic [DATA_WIDTH-1:0] i_wr_data,
	input  logic i_clk_rd,
	input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
	output logic [DATA_WIDTH-1:0] o_rd_data
);

	// One packed RGB pixel per word
	logic [DATA_WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge i_clk_wr) begin
		if (i_we) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// Registered read, one cycle of latency
	always_ff @(posedge i_clk_rd) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// File: hw/sync_to_blanking.sv
`timescale 1ns/100ps

module sync_to_blanking #(
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
	parameter int H_FRONT = video_pkg::DEF_H_FRONT,
	parameter int H_SYNC = video_pkg::DEF_H_SYNC,
	parameter int H_BACK = video_pkg::DEF_H_BACK,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
	parameter int V_FRONT = video_pkg::DEF_V_FRONT,
	parameter int V_SYNC = video_pkg::DEF_V_SYNC,
	parameter int V_BACK = video_pkg::DEF_V_BACK
) (
	input  logic i_clk_b,
	input  logic i_rst_n,
	input  logic i_hsync_n,
	input  logic i_vsync_n,
	video_timing_if.src o_timing
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HW = $clog2(H_TOTAL + 1);
	localparam int VW = $clog2(V_TOTAL + 1);
	// End of the active window, counted from the sync rising edge
	localparam int H_END = H_BACK + H_ACTIVE;
	localparam int V_END = V_BACK + V_ACTIVE;

	logic [1:0] rst_sync;
	logic rst_n;
	logic hs_q;
	logic vs_q;
	logic h_rise;
	logic v_rise;
	logic [HW-1:0] h_pos;
	logic [HW-1:0] h_pos_next;
	logic [VW-1:0] v_pos;
	logic [VW-1:0] v_pos_next;
	logic hblank_q;
	logic vblank_q;

	always_ff @(posedge i_clk_b or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rst_sync <= 2'b00;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
		end
	end

	assign rst_n = rst_sync[1];

	assign h_rise = i_hsync_n && !hs_q;
	assign v_rise = i_vsync_n && !vs_q;

	////////////////////
	// Porch counters, saturating past the active window

	always_comb begin
		if (h_rise) begin
			h_pos_next = '0;
		end else if (int'(h_pos) < H_END) begin
			h_pos_next = h_pos + 1'b1;
		end else begin
			h_pos_next = h_pos;
		end

		// Lines are counted on hsync rising edges
		if (v_rise) begin
			v_pos_next = '0;
		end else if (h_rise && int'(v_pos) < V_END) begin
			v_pos_next = v_pos + 1'b1;
		end else begin
			v_pos_next = v_pos;
		end
	end

	always_ff @(posedge i_clk_b or negedge rst_n) begin
		if (!rst_n) begin
			hs_q <= 1'b1;
			vs_q <= 1'b1;
			h_pos <= HW'(H_END);
			v_pos <= VW'(V_END);
			hblank_q <= 1'b1;
			vblank_q <= 1'b1;
		end else begin
			hs_q <= i_hsync_n;
			vs_q <= i_vsync_n;
			h_pos <= h_pos_next;
			v_pos <= v_pos_next;
			hblank_q <= int'(h_pos_next) < H_BACK || int'(h_pos_next) >= H_END;
			vblank_q <= int'(v_pos_next) < V_BACK || int'(v_pos_next) >= V_END;
		end
	end

	assign o_timing.hsync_n = hs_q;
	assign o_timing.vsync_n = vs_q;
	assign o_timing.hblank = hblank_q;
	assign o_timing.vblank = vblank_q;

	// Whole hsync pulse sits inside horizontal blanking
	a_sync_in_blank: assert property (@(posedge i_clk_b) disable iff (!rst_n)
		$fell(hs_q) |-> (hblank_q && !hs_q) [*H_SYNC] ##1 hs_q);

endmodule

// File: hw/upscaler.sv
`timescale 1ns/100ps

module upscaler #(
	parameter int COMPONENT_DEPTH = 4,
	parameter int LINE_BUFFER_COUNT = 64
) (
	input  logic i_rst_n,

	// Source stream, domain A
	input  logic i_clk_a,
	input  logic [COMPONENT_DEPTH-1:0] i_red_a,
	input  logic [COMPONENT_DEPTH-1:0] i_green_a,
	input  logic [COMPONENT_DEPTH-1:0] i_blue_a,
	video_timing_if.snk i_timing_a,
	input  video_pkg::dim_t i_width_a,
	input  video_pkg::dim_t i_height_a,

	// Output stream, domain B
	input  logic i_clk_b,
	video_timing_if.snk i_timing_b,
	input  video_pkg::dim_t i_width_b,
	input  video_pkg::dim_t i_height_b,
	input  logic i_locked_a,
	input  logic i_locked_b,

	output logic o_hsync_n_b,
	output logic o_vsync_n_b,
	output logic [COMPONENT_DEPTH-1:0] o_red_b,
	output logic [COMPONENT_DEPTH-1:0] o_green_b,
	output logic [COMPONENT_DEPTH-1:0] o_blue_b
);

	import video_pkg::*;

	localparam int PIXEL_WIDTH = 3 * COMPONENT_DEPTH;
	// Ring slot in the upper bits, pixel index in the lower
	localparam int RAM_DEPTH = LINE_BUFFER_COUNT << DIM_WIDTH;
	localparam int ADDR_WIDTH = $clog2(RAM_DEPTH);
	localparam int LINE_BITS = ADDR_WIDTH - DIM_WIDTH;

	logic [1:0] rst_sync_a;
	logic [1:0] rst_sync_b;
	logic rst_a_n;
	logic rst_b_n;

	logic active_a;
	logic active_a_q;
	logic vs_a_q;
	dim_t wr_x;
	logic [LINE_BITS-1:0] wr_line;
	logic [ADDR_WIDTH-1:0] wr_addr;
	logic [PIXEL_WIDTH-1:0] wr_data;

	dim_t width_a_s1;
	dim_t width_a_s2;
	dim_t height_a_s1;
	dim_t height_a_s2;
	logic locked_a_s1;
	logic locked_a_s2;

	logic active_b;
	logic active_b_q;
	dim_t src_x;
	dim_t src_y;
	logic [DIM_WIDTH:0] acc_x;
	logic [DIM_WIDTH:0] acc_y;
	logic [DIM_WIDTH:0] acc_x_sum;
	logic [DIM_WIDTH:0] acc_y_sum;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic [PIXEL_WIDTH-1:0] rd_data;
	logic hs_d1;
	logic vs_d1;
	logic blank_d1;
	logic lock_ok;

	always_ff @(posedge i_clk_a or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rst_sync_a <= 2'b00;
		end else begin
			rst_sync_a <= {rst_sync_a[0], 1'b1};
		end
	end

	always_ff @(posedge i_clk_b or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rst_sync_b <= 2'b00;
		end else begin
			rst_sync_b <= {rst_sync_b[0], 1'b1};
		end
	end

	assign rst_a_n = rst_sync_a[1];
	assign rst_b_n = rst_sync_b[1];

	////////////////////
	// Write side, domain A

	assign active_a = !i_timing_a.hblank && !i_timing_a.vblank;
	assign wr_addr = {wr_line, wr_x};
	assign wr_data = {i_red_a, i_green_a, i_blue_a};

	always_ff @(posedge i_clk_a or negedge rst_a_n) begin
		if (!rst_a_n) begin
			active_a_q <= 1'b0;
			vs_a_q <= 1'b1;
			wr_x <= '0;
			wr_line <= '0;
		end else begin
			active_a_q <= active_a;
			vs_a_q <= i_timing_a.vsync_n;
			if (active_a) begin
				wr_x <= wr_x + 1'b1;
			end else if (active_a_q) begin
				// Line done, move on to the next ring slot
				wr_x <= '0;
				if (wr_line == LINE_BITS'(LINE_BUFFER_COUNT - 1)) begin
					wr_line <= '0;
				end else begin
					wr_line <= wr_line + 1'b1;
				end
			end
			// New source frame restarts at slot 0
			if (vs_a_q && !i_timing_a.vsync_n) begin
				wr_line <= '0;
			end
		end
	end

	// Source image has to fit in the ring
	a_ring_holds_frame: assert property (@(posedge i_clk_a) disable iff (!rst_a_n)
		i_locked_a |-> int'(i_height_a) <= LINE_BUFFER_COUNT);

	// Source dimensions and lock into domain B, two flops, no handshake
	always_ff @(posedge i_clk_b or negedge rst_b_n) begin
		if (!rst_b_n) begin
			width_a_s1 <= '0;
			width_a_s2 <= '0;
			height_a_s1 <= '0;
			height_a_s2 <= '0;
			locked_a_s1 <= 1'b0;
			locked_a_s2 <= 1'b0;
		end else begin
			width_a_s1 <= i_width_a;
			width_a_s2 <= width_a_s1;
			height_a_s1 <= i_height_a;
			height_a_s2 <= height_a_s1;
			locked_a_s1 <= i_locked_a;
			locked_a_s2 <= locked_a_s1;
		end
	end

	////////////////////
	// Read side, DDA stepping in domain B

	assign active_b = !i_timing_b.hblank && !i_timing_b.vblank;
	assign acc_x_sum = acc_x + {1'b0, width_a_s2};
	assign acc_y_sum = acc_y + {1'b0, height_a_s2};
	// src_y stays below the ring size, so it is the slot directly
	assign rd_addr = {LINE_BITS'(src_y), src_x};
	assign lock_ok = locked_a_s2 && i_locked_b;

	// Single step per pixel, output is never narrower than the source
	always_ff @(posedge i_clk_b or negedge rst_b_n) begin
		if (!rst_b_n) begin
			active_b_q <= 1'b0;
			src_x <= '0;
			acc_x <= '0;
			src_y <= '0;
			acc_y <= '0;
		end else begin
			active_b_q <= active_b;

			if (!active_b) begin
				src_x <= '0;
				acc_x <= '0;
			end else if (acc_x_sum >= {1'b0, i_width_b}) begin
				src_x <= src_x + 1'b1;
				acc_x <= acc_x_sum - {1'b0, i_width_b};
			end else begin
				acc_x <= acc_x_sum;
			end

			// Vertical step once per finished output line
			if (i_timing_b.vblank) begin
				src_y <= '0;
				acc_y <= '0;
			end else if (active_b_q && !active_b) begin
				if (acc_y_sum >= {1'b0, i_height_b}) begin
					src_y <= src_y + 1'b1;
					acc_y <= acc_y_sum - {1'b0, i_height_b};
				end else begin
					acc_y <= acc_y_sum;
				end
			end
		end
	end

	line_buffer_ram #(
		.DATA_WIDTH(PIXEL_WIDTH),
		.DEPTH(RAM_DEPTH)
	) line_ring (
		.i_clk_wr(i_clk_a),
		.i_we(active_a),
		.i_wr_addr(wr_addr),
		.i_wr_data(wr_data),
		.i_clk_rd(i_clk_b),
		.i_rd_addr(rd_addr),
		.o_rd_data(rd_data)
	);

	// Two stages to match the RAM read latency
	always_ff @(posedge i_clk_b or negedge rst_b_n) begin
		if (!rst_b_n) begin
			hs_d1 <= 1'b1;
			vs_d1 <= 1'b1;
			blank_d1 <= 1'b1;
			o_hsync_n_b <= 1'b1;
			o_vsync_n_b <= 1'b1;
			{o_red_b, o_green_b, o_blue_b} <= '0;
		end else begin
			hs_d1 <= i_timing_b.hsync_n;
			vs_d1 <= i_timing_b.vsync_n;
			blank_d1 <= !active_b;
			o_hsync_n_b <= hs_d1;
			o_vsync_n_b <= vs_d1;
			if (blank_d1 || !lock_ok) begin
				{o_red_b, o_green_b, o_blue_b} <= '0;
			end else begin
				{o_red_b, o_green_b, o_blue_b} <= rd_data;
			end
		end
	end

endmodule

// File: hw/vga_sync_pulses.sv
`timescale 1ns/100ps

module vga_sync_pulses #(
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
	parameter int H_FRONT = video_pkg::DEF_H_FRONT,
	parameter int H_SYNC = video_pkg::DEF_H_SYNC,
	parameter int H_BACK = video_pkg::DEF_H_BACK,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
	parameter int V_FRONT = video_pkg::DEF_V_FRONT,
	parameter int V_SYNC = video_pkg::DEF_V_SYNC,
	parameter int V_BACK = video_pkg::DEF_V_BACK
) (
	input  logic i_clk_b,
	input  logic i_rst_n,
	output logic o_hsync_n,
	output logic o_vsync_n
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int HS_END = HS_START + H_SYNC;
	localparam int VS_START = V_ACTIVE + V_FRONT;
	localparam int VS_END = VS_START + V_SYNC;

	logic [1:0] rst_sync;
	logic rst_n;
	logic [HW-1:0] h_cnt;
	logic [HW-1:0] h_next;
	logic [VW-1:0] v_cnt;
	logic [VW-1:0] v_next;

	// Local release of reset
	always_ff @(posedge i_clk_b or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rst_sync <= 2'b00;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
		end
	end

	assign rst_n = rst_sync[1];

	// Line wraps first, frame advances on the wrap
	always_comb begin
		h_next = h_cnt + 1'b1;
		v_next = v_cnt;
		if (h_cnt == HW'(H_TOTAL - 1)) begin
			h_next = '0;
			if (v_cnt == VW'(V_TOTAL - 1)) begin
				v_next = '0;
			end else begin
				v_next = v_cnt + 1'b1;
			end
		end
	end

	// Syncs registered from the next position so they line up with the counters
	always_ff @(posedge i_clk_b or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			o_hsync_n <= !(int'(h_next) >= HS_START && int'(h_next) < HS_END);
			o_vsync_n <= !(int'(v_next) >= VS_START && int'(v_next) < VS_END);
		end
	end

	a_counters_in_frame: assert property (@(posedge i_clk_b) disable iff (!rst_n)
		int'(h_cnt) < H_TOTAL && int'(v_cnt) < V_TOTAL);

endmodule

// File: hw/video_out_top.sv
`timescale 1ns/100ps

module video_out_top #(
	parameter int COMPONENT_DEPTH = 4,
	parameter int LINE_BUFFER_COUNT = 64,
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
	parameter int H_FRONT = video_pkg::DEF_H_FRONT,
	parameter int H_SYNC = video_pkg::DEF_H_SYNC,
	parameter int H_BACK = video_pkg::DEF_H_BACK,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
	parameter int V_FRONT = video_pkg::DEF_V_FRONT,
	parameter int V_SYNC = video_pkg::DEF_V_SYNC,
	parameter int V_BACK = video_pkg::DEF_V_BACK
) (
	input  logic i_clk_a,
	input  logic i_clk_b,
	input  logic i_rst_n,

	// Source video
	input  logic [COMPONENT_DEPTH-1:0] i_red_a,
	input  logic [COMPONENT_DEPTH-1:0] i_green_a,
	input  logic [COMPONENT_DEPTH-1:0] i_blue_a,
	input  logic i_hsync_n_a,
	input  logic i_vsync_n_a,
	input  logic i_hblank_a,
	input  logic i_vblank_a,

	// Measurements
	output logic o_locked_a,
	output video_pkg::dim_t o_width_a,
	output video_pkg::dim_t o_height_a,
	output logic o_locked_b,
	output video_pkg::dim_t o_width_b,
	output video_pkg::dim_t o_height_b,

	// Scaled output video
	output logic o_hsync_n_b,
	output logic o_vsync_n_b,
	output logic [COMPONENT_DEPTH-1:0] o_red_b,
	output logic [COMPONENT_DEPTH-1:0] o_green_b,
	output logic [COMPONENT_DEPTH-1:0] o_blue_b
);

	logic raw_hsync_n;
	logic raw_vsync_n;

	video_timing_if timing_a ();
	video_timing_if timing_b ();

	assign timing_a.hsync_n = i_hsync_n_a;
	assign timing_a.vsync_n = i_vsync_n_a;
	assign timing_a.hblank = i_hblank_a;
	assign timing_a.vblank = i_vblank_a;

	////////////////////
	// Output timing chain

	vga_sync_pulses #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) output_sync_gen (
		.i_clk_b(i_clk_b),
		.i_rst_n(i_rst_n),
		.o_hsync_n(raw_hsync_n),
		.o_vsync_n(raw_vsync_n)
	);

	sync_to_blanking #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) output_blanking (
		.i_clk_b(i_clk_b),
		.i_rst_n(i_rst_n),
		.i_hsync_n(raw_hsync_n),
		.i_vsync_n(raw_vsync_n),
		.o_timing(timing_b.src)
	);

	// Measurement of both streams
	frame_measure measure_a (
		.i_clk(i_clk_a),
		.i_rst_n(i_rst_n),
		.i_timing(timing_a.snk),
		.o_locked(o_locked_a),
		.o_width(o_width_a),
		.o_height(o_height_a)
	);

	frame_measure measure_b (
		.i_clk(i_clk_b),
		.i_rst_n(i_rst_n),
		.i_timing(timing_b.snk),
		.o_locked(o_locked_b),
		.o_width(o_width_b),
		.o_height(o_height_b)
	);

	upscaler #(
		.COMPONENT_DEPTH(COMPONENT_DEPTH),
		.LINE_BUFFER_COUNT(LINE_BUFFER_COUNT)
	) scaler (
		.i_rst_n(i_rst_n),
		.i_clk_a(i_clk_a),
		.i_red_a(i_red_a),
		.i_green_a(i_green_a),
		.i_blue_a(i_blue_a),
		.i_timing_a(timing_a.snk),
		.i_width_a(o_width_a),
		.i_height_a(o_height_a),
		.i_clk_b(i_clk_b),
		.i_timing_b(timing_b.snk),
		.i_width_b(o_width_b),
		.i_height_b(o_height_b),
		.i_locked_a(o_locked_a),
		.i_locked_b(o_locked_b),
		.o_hsync_n_b(o_hsync_n_b),
		.o_vsync_n_b(o_vsync_n_b),
		.o_red_b(o_red_b),
		.o_green_b(o_green_b),
		.o_blue_b(o_blue_b)
	);

endmodule

// File: hw/video_pkg.sv
package video_pkg;

	// Pixel and line counts
	localparam int DIM_WIDTH = 12;

	typedef logic [DIM_WIDTH-1:0] dim_t;

	////////////////////
	// Default output timing, 640x480 VGA

	localparam int DEF_H_ACTIVE = 640;
	localparam int DEF_H_FRONT = 16;
	localparam int DEF_H_SYNC = 96;
	localparam int DEF_H_BACK = 48;

	// Vertical values are in lines
	localparam int DEF_V_ACTIVE = 480;
	localparam int DEF_V_FRONT = 10;
	localparam int DEF_V_SYNC = 2;
	localparam int DEF_V_BACK = 33;

endpackage

// File: hw/video_timing_if.sv
`timescale 1ns/100ps

interface video_timing_if;

	// Syncs are active low, blanking is active high
	logic hsync_n;
	logic vsync_n;
	logic hblank;
	logic vblank;

	modport src (
		output hsync_n,
		output vsync_n,
		output hblank,
		output vblank
	);

	modport snk (
		input hsync_n,
		input vsync_n,
		input hblank,
		input vblank
	);

endinterface

// File: sim/video_out_tb.sv
`timescale 1ns/100ps

module video_out_tb;

	import video_pkg::*;

	// Small output raster keeps the run short
	localparam int H_ACTIVE = 40;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 6;
	localparam int H_BACK = 6;
	localparam int V_ACTIVE = 30;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 3;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

	// Source raster, porches in pixels and lines
	localparam int SRC_W = 24;
	localparam int SRC_W_NARROW = 20;
	localparam int SRC_H = 18;
	localparam int SRC_H_FRONT = 3;
	localparam int SRC_H_SYNC = 4;
	localparam int SRC_H_BACK = 5;
	localparam int SRC_V_FRONT = 2;
	localparam int SRC_V_SYNC = 2;
	localparam int SRC_V_BACK = 3;
	localparam int SRC_H_BLANK = SRC_H_FRONT + SRC_H_SYNC + SRC_H_BACK;
	localparam int SRC_V_TOTAL = SRC_H + SRC_V_FRONT + SRC_V_SYNC + SRC_V_BACK;
	localparam int SRC_FRAME_CYCLES = (SRC_W + SRC_H_BLANK) * SRC_V_TOTAL;

	logic clk_a;
	logic clk_b;
	logic rst_n;
	logic [3:0] red_a;
	logic [3:0] green_a;
	logic [3:0] blue_a;
	logic hsync_n_a;
	logic vsync_n_a;
	logic hblank_a;
	logic vblank_a;
	logic locked_a;
	logic locked_b;
	dim_t width_a;
	dim_t height_a;
	dim_t width_b;
	dim_t height_b;
	logic hsync_n_b;
	logic vsync_n_b;
	logic [3:0] red_b;
	logic [3:0] green_b;
	logic [3:0] blue_b;

	logic [11:0] img [SRC_H][SRC_W];
	integer seed;
	int src_width;
	int cur_width;
	int sx;
	int sy;
	int errors;
	int tests_run;
	int tests_failed;
	int errs_before;

	always #10 clk_b = ~clk_b;
	always #18.5 clk_a = ~clk_a;

	video_out_top #(
		.COMPONENT_DEPTH(4),
		.LINE_BUFFER_COUNT(32),
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) uut (
		.i_clk_a(clk_a),
		.i_clk_b(clk_b),
		.i_rst_n(rst_n),
		.i_red_a(red_a),
		.i_green_a(green_a),
		.i_blue_a(blue_a),
		.i_hsync_n_a(hsync_n_a),
		.i_vsync_n_a(vsync_n_a),
		.i_hblank_a(hblank_a),
		.i_vblank_a(vblank_a),
		.o_locked_a(locked_a),
		.o_width_a(width_a),
		.o_height_a(height_a),
		.o_locked_b(locked_b),
		.o_width_b(width_b),
		.o_height_b(height_b),
		.o_hsync_n_b(hsync_n_b),
		.o_vsync_n_b(vsync_n_b),
		.o_red_b(red_b),
		.o_green_b(green_b),
		.o_blue_b(blue_b)
	);

	////////////////////
	// Source generator, width latched at each frame start

	always @(posedge clk_a) begin
		if (!rst_n) begin
			sx <= 0;
			sy <= 0;
			cur_width <= src_width;
			{red_a, green_a, blue_a} <= '0;
			hsync_n_a <= 1'b1;
			vsync_n_a <= 1'b1;
			hblank_a <= 1'b1;
			vblank_a <= 1'b1;
		end else begin
			hblank_a <= sx >= cur_width;
			vblank_a <= sy >= SRC_H;
			hsync_n_a <= !(sx >= cur_width + SRC_H_FRONT &&
				sx < cur_width + SRC_H_FRONT + SRC_H_SYNC);
			vsync_n_a <= !(sy >= SRC_H + SRC_V_FRONT &&
				sy < SRC_H + SRC_V_FRONT + SRC_V_SYNC);
			if (sx < cur_width && sy < SRC_H) begin
				{red_a, green_a, blue_a} <= img[sy][sx];
			end else begin
				{red_a, green_a, blue_a} <= '0;
			end
			if (sx == cur_width + SRC_H_BLANK - 1) begin
				sx <= 0;
				if (sy == SRC_V_TOTAL - 1) begin
					sy <= 0;
					cur_width <= src_width;
				end else begin
					sy <= sy + 1;
				end
			end else begin
				sx <= sx + 1;
			end
		end
	end

	////////////////////
	// Helpers

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d error(s)", tests_run, name, errors - errs_before);
		end
		errs_before = errors;
	endtask

	// Call on a clk_b falling edge; returns cycles until the sync reaches the level
	task automatic wait_sync_level(input bit use_vsync, input logic level, input int limit,
		output int cycles);
		logic s;
		cycles = 0;
		s = use_vsync ? vsync_n_b : hsync_n_b;
		while (s !== level && cycles < limit) begin
			@(negedge clk_b);
			cycles++;
			s = use_vsync ? vsync_n_b : hsync_n_b;
		end
		if (s !== level) begin
			$display("timeout: %s did not reach %b within %0d cycles",
				use_vsync ? "o_vsync_n_b" : "o_hsync_n_b", level, limit);
			errors++;
		end
	endtask

	task automatic wait_locked(input bit side_b, input logic level, input int limit);
		int n;
		logic flag;
		n = 0;
		do begin
			if (side_b) begin
				@(negedge clk_b);
			end else begin
				@(negedge clk_a);
			end
			n++;
			flag = side_b ? locked_b : locked_a;
		end while (flag !== level && n < limit);
		if (flag !== level) begin
			$display("timeout: %s did not reach %b within %0d cycles",
				side_b ? "o_locked_b" : "o_locked_a", level, limit);
			errors++;
		end
	endtask

	task automatic check_dims(input string name, input dim_t w, input dim_t h,
		input int exp_w, input int exp_h);
		if (int'(w) != exp_w || int'(h) != exp_h) begin
			$display("FAIL %0t: %s measured %0dx%0d, expected %0dx%0d",
				$time, name, w, h, exp_w, exp_h);
			errors++;
		end
	endtask

	task automatic check_sync_timing(input bit use_vsync, input int pulse, input int period);
		int n;
		int high_len;
		int low_len;
		@(negedge clk_b);
		wait_sync_level(use_vsync, 1'b0, period * 2, n);
		wait_sync_level(use_vsync, 1'b1, period * 2, n);
		wait_sync_level(use_vsync, 1'b0, period * 2, high_len);
		wait_sync_level(use_vsync, 1'b1, period * 2, low_len);
		if (low_len != pulse || high_len + low_len != period) begin
			$display("FAIL %0t: %s pulse %0d period %0d, expected %0d and %0d", $time,
				use_vsync ? "vsync" : "hsync", low_len, high_len + low_len, pulse, period);
			errors++;
		end
	endtask

	// Walks one output frame from the vsync rising edge
	task automatic scan_frame(input int wa, input int ha, input bit chk_active,
		input bit chk_blank);
		int n;
		int hpos;
		int line_num;
		int x;
		int y;
		logic hs_prev;
		logic [11:0] got;
		logic [11:0] expect_px;
		bit in_active;
		@(negedge clk_b);
		wait_sync_level(1'b1, 1'b0, FRAME_CYCLES * 2, n);
		wait_sync_level(1'b1, 1'b1, FRAME_CYCLES * 2, n);
		line_num = 0;
		hpos = 0;
		hs_prev = hsync_n_b;
		for (int i = 0; i < FRAME_CYCLES; i++) begin
			if (hsync_n_b && !hs_prev) begin
				line_num++;
				hpos = 0;
			end else begin
				hpos++;
			end
			hs_prev = hsync_n_b;
			y = line_num - V_BACK;
			x = hpos - H_BACK;
			in_active = y >= 0 && y < V_ACTIVE && x >= 0 && x < H_ACTIVE;
			got = {red_b, green_b, blue_b};
			// Nearest neighbour, floor of the scaled position
			expect_px = in_active ? img[(y * ha) / V_ACTIVE][(x * wa) / H_ACTIVE] : 12'h000;
			if (got !== expect_px && (in_active ? chk_active : chk_blank)) begin
				$display("FAIL %0t: %s pixel x=%0d y=%0d is %h, expected %h", $time,
					in_active ? "active" : "blanking", x, y, got, expect_px);
				errors++;
			end
			@(negedge clk_b);
		end
	endtask

	////////////////////
	// Test sequence

	initial begin
		clk_a = 1'b0;
		clk_b = 1'b0;
		rst_n = 1'b0;
		{red_a, green_a, blue_a} = '0;
		hsync_n_a = 1'b1;
		vsync_n_a = 1'b1;
		hblank_a = 1'b1;
		vblank_a = 1'b1;
		src_width = SRC_W;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		errs_before = 0;

		// Static random image
		seed = 32'h7564e171;
		for (int y = 0; y < SRC_H; y++) begin
			for (int x = 0; x < SRC_W; x++) begin
				img[y][x] = 12'($random(seed));
			end
		end

		repeat (10) @(posedge clk_b);
		rst_n <= 1'b1;

		for (int i = 0; i < 100; i++) begin
			@(negedge clk_b);
			if (locked_a !== 1'b0 || locked_b !== 1'b0) begin
				$display("FAIL %0t: lock set right after reset", $time);
				errors++;
			end
			if ({red_b, green_b, blue_b} !== 12'h000) begin
				$display("FAIL %0t: pixel %h after reset", $time, {red_b, green_b, blue_b});
				errors++;
			end
		end
		finish_test("reset state");

		wait_locked(1'b0, 1'b1, 6 * SRC_FRAME_CYCLES);
		check_dims("source", width_a, height_a, SRC_W, SRC_H);
		finish_test("source lock");

		wait_locked(1'b1, 1'b1, 6 * FRAME_CYCLES);
		check_dims("output", width_b, height_b, H_ACTIVE, V_ACTIVE);
		finish_test("output lock");

		check_sync_timing(1'b0, H_SYNC, H_TOTAL);
		check_sync_timing(1'b1, V_SYNC * H_TOTAL, FRAME_CYCLES);
		finish_test("output sync timing");

		scan_frame(SRC_W, SRC_H, 1'b1, 1'b0);
		finish_test("scaled active pixels");

		scan_frame(SRC_W, SRC_H, 1'b0, 1'b1);
		finish_test("blanking pixels");

		// Narrower source lines force a relock
		src_width = SRC_W_NARROW;
		wait_locked(1'b0, 1'b0, 4 * SRC_FRAME_CYCLES);
		wait_locked(1'b0, 1'b1, 4 * SRC_FRAME_CYCLES);
		check_dims("narrow source", width_a, height_a, SRC_W_NARROW, SRC_H);
		scan_frame(SRC_W_NARROW, SRC_H, 1'b1, 1'b1);
		finish_test("width change relock");

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
